//--- logic/mkey_consts.svh
//------------------------------
// Security key control block constants
// Bus widths, register map, field bits and reset values
//------------------------------
`ifndef MKEY_CONSTS_SVH
`define MKEY_CONSTS_SVH

// Bus widths
`define MKEY_ADDR_BITS 8
`define MKEY_DATA_BITS 32

//------------------------------
// Word address map
//------------------------------
`define MKEY_ADDR_NAME0      8'h00
`define MKEY_ADDR_NAME1      8'h01
`define MKEY_ADDR_VERSION    8'h02
`define MKEY_ADDR_SWITCH_APP 8'h08
`define MKEY_ADDR_LED        8'h09
`define MKEY_ADDR_GPIO       8'h0a
`define MKEY_ADDR_APP_START  8'h0c
`define MKEY_ADDR_APP_SIZE   8'h0d
`define MKEY_ADDR_DEBUG      8'h10
`define MKEY_ADDR_CDI_FIRST  8'h20
`define MKEY_ADDR_CDI_LAST   8'h27
`define MKEY_ADDR_UDI_FIRST  8'h30
`define MKEY_ADDR_UDI_LAST   8'h31

// LED and GPIO field positions
`define MKEY_LED_R_BIT 2
`define MKEY_LED_G_BIT 1
`define MKEY_LED_B_BIT 0
`define MKEY_GPIO1_BIT 0
`define MKEY_GPIO2_BIT 1
`define MKEY_GPIO3_BIT 2
`define MKEY_GPIO4_BIT 3

//------------------------------
// Identity, UDI and reset values
//------------------------------
`define MKEY_NAME0     32'h6d6b6579
`define MKEY_NAME1     32'h6374726c
`define MKEY_VERSION   32'h00000001
`define MKEY_UDI0      32'h0a1b2c3d
`define MKEY_UDI1      32'h4e5f6071
// Red and green lit out of reset
`define MKEY_LED_RESET 3'h6

`endif

//--- logic/mkey_pkg.sv
//------------------------------
// Shared types for the security key control block
//------------------------------
package mkey_pkg;

  // Bridge FSM states
  typedef enum logic [1:0] {
    BR_IDLE   = 2'd0,
    BR_ACCESS = 2'd1,
    BR_RESP   = 2'd2
  } bridge_state_e;

  // Host request opcode
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } host_cmd_e;

endpackage

//--- logic/host_bridge.sv
//------------------------------
// Host request bridge
// Turns one valid/ready request into one chip-select access
//------------------------------
`timescale 1ns/1ps
`include "mkey_consts.svh"

module host_bridge (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        req_valid,
  input  mkey_pkg::host_cmd_e         req_cmd,
  input  logic [`MKEY_ADDR_BITS-1:0]  req_addr,
  input  logic [`MKEY_DATA_BITS-1:0]  req_wdata,
  output logic                        req_ready,
  output logic                        resp_valid,
  output logic [`MKEY_DATA_BITS-1:0]  resp_rdata,
  input  logic                        resp_ready,
  output logic                        cs,
  output logic                        we,
  output logic [`MKEY_ADDR_BITS-1:0]  address,
  output logic [`MKEY_DATA_BITS-1:0]  write_data,
  input  logic [`MKEY_DATA_BITS-1:0]  read_data,
  input  logic                        ready
);

  mkey_pkg::bridge_state_e state;
  mkey_pkg::bridge_state_e state_next;

  // Latched request and held response
  mkey_pkg::host_cmd_e         cmd_reg;
  logic [`MKEY_ADDR_BITS-1:0]  addr_reg;
  logic [`MKEY_DATA_BITS-1:0]  wdata_reg;
  logic [`MKEY_DATA_BITS-1:0]  rdata_reg;

  logic req_fire;
  logic bus_done;
  logic resp_fire;

  assign req_ready  = (state == mkey_pkg::BR_IDLE);
  assign cs         = (state == mkey_pkg::BR_ACCESS);
  assign resp_valid = (state == mkey_pkg::BR_RESP);

  // we only meaningful while cs is up
  assign we         = cs && (cmd_reg == mkey_pkg::CMD_WRITE);
  assign address    = addr_reg;
  assign write_data = wdata_reg;
  assign resp_rdata = rdata_reg;

  assign req_fire  = req_valid && req_ready;
  assign bus_done  = cs && ready;
  assign resp_fire = resp_valid && resp_ready;

  //------------------------------
  // FSM
  //------------------------------
  always_comb begin
    state_next = state;
    case (state)
      mkey_pkg::BR_IDLE: begin
        if (req_fire) begin
          state_next = mkey_pkg::BR_ACCESS;
        end
      end
      mkey_pkg::BR_ACCESS: begin
        if (bus_done) begin
          state_next = mkey_pkg::BR_RESP;
        end
      end
      mkey_pkg::BR_RESP: begin
        // Wait out host back-pressure
        if (resp_fire) begin
          state_next = mkey_pkg::BR_IDLE;
        end
      end
      default: state_next = mkey_pkg::BR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= mkey_pkg::BR_IDLE;
    end else begin
      state <= state_next;
    end
  end

  //------------------------------
  // Request and response payload
  //------------------------------
  always_ff @(posedge clk) begin
    if (req_fire) begin
      cmd_reg   <= req_cmd;
      addr_reg  <= req_addr;
      wdata_reg <= req_wdata;
    end
    // Writes answer with zero data
    if (bus_done) begin
      rdata_reg <= we ? '0 : read_data;
    end
  end

endmodule

//--- logic/sys_ctrl_regs.sv
//------------------------------
// System control registers
// Identity, mode lock, LED, GPIO, app window, debug, CDI and UDI
//------------------------------
`timescale 1ns/1ps
`include "mkey_consts.svh"

module sys_ctrl_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        cs,
  input  logic                        we,
  input  logic [`MKEY_ADDR_BITS-1:0]  address,
  input  logic [`MKEY_DATA_BITS-1:0]  write_data,
  output logic [`MKEY_DATA_BITS-1:0]  read_data,
  output logic                        ready,
  output logic                        fw_app_mode,
  output logic                        led_r,
  output logic                        led_g,
  output logic                        led_b,
  input  logic                        gpio1,
  input  logic                        gpio2,
  output logic                        gpio3,
  output logic                        gpio4
);

  // Control state
  logic       switch_app_reg;
  logic [2:0] led_reg;
  logic       gpio3_reg;
  logic       gpio4_reg;
  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;

  // Stored words
  logic [`MKEY_DATA_BITS-1:0] app_start_reg;
  logic [`MKEY_DATA_BITS-1:0] app_size_reg;
  logic [`MKEY_DATA_BITS-1:0] debug_reg;
  logic [`MKEY_DATA_BITS-1:0] cdi_mem [0:7];

  logic                       wr_access;
  logic                       rd_access;
  logic                       cdi_hit;
  logic                       udi_hit;
  logic                       switch_app_we;
  logic                       led_we;
  logic                       gpio_we;
  logic                       app_start_we;
  logic                       app_size_we;
  logic                       debug_we;
  logic                       cdi_we;
  logic [3:0]                 gpio_status;
  logic [`MKEY_DATA_BITS-1:0] udi_word;

  // Single-cycle access
  assign ready = cs;

  assign fw_app_mode = switch_app_reg;
  assign led_r       = led_reg[`MKEY_LED_R_BIT];
  assign led_g       = led_reg[`MKEY_LED_G_BIT];
  assign led_b       = led_reg[`MKEY_LED_B_BIT];
  assign gpio3       = gpio3_reg;
  assign gpio4       = gpio4_reg;

  //------------------------------
  // Address decode
  //------------------------------
  assign wr_access = cs && we;
  assign rd_access = cs && !we;

  assign cdi_hit = (address >= `MKEY_ADDR_CDI_FIRST) && (address <= `MKEY_ADDR_CDI_LAST);
  assign udi_hit = (address >= `MKEY_ADDR_UDI_FIRST) && (address <= `MKEY_ADDR_UDI_LAST);

  assign switch_app_we = wr_access && (address == `MKEY_ADDR_SWITCH_APP);
  assign led_we        = wr_access && (address == `MKEY_ADDR_LED);
  assign gpio_we       = wr_access && (address == `MKEY_ADDR_GPIO);
  assign debug_we      = wr_access && (address == `MKEY_ADDR_DEBUG);

  // Locked once the app has been started
  assign app_start_we = wr_access && !switch_app_reg && (address == `MKEY_ADDR_APP_START);
  assign app_size_we  = wr_access && !switch_app_reg && (address == `MKEY_ADDR_APP_SIZE);
  assign cdi_we       = wr_access && !switch_app_reg && cdi_hit;

  //------------------------------
  // Control registers
  //------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      switch_app_reg <= 1'b0;
      led_reg        <= `MKEY_LED_RESET;
      gpio3_reg      <= 1'b0;
      gpio4_reg      <= 1'b0;
      gpio1_sync     <= 2'b00;
      gpio2_sync     <= 2'b00;
    end else begin
      // Two-stage synchronizers for the input pins
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};

      // Sticky until the next reset
      if (switch_app_we) begin
        switch_app_reg <= 1'b1;
      end
      if (led_we) begin
        led_reg <= write_data[2:0];
      end
      if (gpio_we) begin
        gpio3_reg <= write_data[`MKEY_GPIO3_BIT];
        gpio4_reg <= write_data[`MKEY_GPIO4_BIT];
      end
    end
  end

  // Word storage
  always_ff @(posedge clk) begin
    if (app_start_we) begin
      app_start_reg <= write_data;
    end
    if (app_size_we) begin
      app_size_reg <= write_data;
    end
    if (debug_we) begin
      debug_reg <= write_data;
    end
    if (cdi_we) begin
      cdi_mem[address[2:0]] <= write_data;
    end
  end

  //------------------------------
  // Read side
  //------------------------------
  always_comb begin
    gpio_status                  = '0;
    gpio_status[`MKEY_GPIO1_BIT] = gpio1_sync[1];
    gpio_status[`MKEY_GPIO2_BIT] = gpio2_sync[1];
    gpio_status[`MKEY_GPIO3_BIT] = gpio3_reg;
    gpio_status[`MKEY_GPIO4_BIT] = gpio4_reg;
  end

  // Two-word UDI selected by the low address bit
  assign udi_word = address[0] ? `MKEY_UDI1 : `MKEY_UDI0;

  always_comb begin
    read_data = '0;
    if (rd_access) begin
      case (address)
        `MKEY_ADDR_NAME0:      read_data = `MKEY_NAME0;
        `MKEY_ADDR_NAME1:      read_data = `MKEY_NAME1;
        `MKEY_ADDR_VERSION:    read_data = `MKEY_VERSION;
        `MKEY_ADDR_SWITCH_APP: read_data = {`MKEY_DATA_BITS{switch_app_reg}};
        `MKEY_ADDR_LED:        read_data = {29'h0, led_reg};
        `MKEY_ADDR_GPIO:       read_data = {28'h0, gpio_status};
        `MKEY_ADDR_APP_START:  read_data = app_start_reg;
        `MKEY_ADDR_APP_SIZE:   read_data = app_size_reg;
        `MKEY_ADDR_DEBUG:      read_data = debug_reg;
        default: begin
          if (cdi_hit) begin
            read_data = cdi_mem[address[2:0]];
          end else if (udi_hit) begin
            read_data = udi_word;
          end
        end
      endcase
    end
  end

endmodule

//--- logic/mkey_top.sv
//------------------------------
// Security key control top
// Host bridge feeding the system control registers
//------------------------------
`timescale 1ns/1ps
`include "mkey_consts.svh"

module mkey_top (
  input  logic                        clk,
  input  logic                        reset_n,
  // Host request channel
  input  logic                        req_valid,
  input  mkey_pkg::host_cmd_e         req_cmd,
  input  logic [`MKEY_ADDR_BITS-1:0]  req_addr,
  input  logic [`MKEY_DATA_BITS-1:0]  req_wdata,
  output logic                        req_ready,
  // Host response channel
  output logic                        resp_valid,
  output logic [`MKEY_DATA_BITS-1:0]  resp_rdata,
  input  logic                        resp_ready,
  // Pins
  output logic                        fw_app_mode,
  output logic                        led_r,
  output logic                        led_g,
  output logic                        led_b,
  input  logic                        gpio1,
  input  logic                        gpio2,
  output logic                        gpio3,
  output logic                        gpio4
);

  // Chip-select bus
  logic                       cs;
  logic                       we;
  logic [`MKEY_ADDR_BITS-1:0] address;
  logic [`MKEY_DATA_BITS-1:0] write_data;
  logic [`MKEY_DATA_BITS-1:0] read_data;
  logic                       ready;

  host_bridge host_bridge_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .req_valid  (req_valid),
    .req_cmd    (req_cmd),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_ready (resp_ready),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .ready      (ready)
  );

  sys_ctrl_regs sys_ctrl_regs_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .cs          (cs),
    .we          (we),
    .address     (address),
    .write_data  (write_data),
    .read_data   (read_data),
    .ready       (ready),
    .fw_app_mode (fw_app_mode),
    .led_r       (led_r),
    .led_g       (led_g),
    .led_b       (led_b),
    .gpio1       (gpio1),
    .gpio2       (gpio2),
    .gpio3       (gpio3),
    .gpio4       (gpio4)
  );

endmodule

//--- testbench/mkey_checker.sv
//------------------------------
// Host bridge handshake assertions
//------------------------------
`timescale 1ns/1ps
`include "mkey_consts.svh"

module mkey_checker (
  input logic                       clk,
  input logic                       reset_n,
  input logic                       req_valid,
  input logic                       req_ready,
  input logic                       resp_valid,
  input logic                       resp_ready,
  input logic [`MKEY_DATA_BITS-1:0] resp_rdata,
  input logic                       cs
);

  // Set by the first accepted request
  logic seen_req;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      seen_req <= 1'b0;
    end else if (req_valid && req_ready) begin
      seen_req <= 1'b1;
    end
  end

  // Response held until the host takes it
  resp_held: assert property (@(posedge clk) disable iff (!reset_n)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp_rdata)))
    else $error("Response dropped or changed before resp_ready");

  // Single outstanding access
  no_accept_busy: assert property (@(posedge clk) disable iff (!reset_n)
    (cs || resp_valid) |-> !req_ready)
    else $error("req_ready high while an access is in flight");

  quiet_bus: assert property (@(posedge clk) disable iff (!reset_n)
    !seen_req |-> !cs)
    else $error("cs raised before any request was accepted");

endmodule

//--- testbench/mkey_tb.sv
//------------------------------
// Security key control testbench
// Trace-driven host accesses with response and pin checks
//------------------------------
`timescale 1ns/1ps
`include "mkey_consts.svh"

module mkey_tb;

  localparam int CLK_HALF       = 4;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int GPIO_SETTLE    = 4;

  logic                       clk;
  logic                       reset_n;
  logic                       req_valid;
  mkey_pkg::host_cmd_e        req_cmd;
  logic [`MKEY_ADDR_BITS-1:0] req_addr;
  logic [`MKEY_DATA_BITS-1:0] req_wdata;
  logic                       req_ready;
  logic                       resp_valid;
  logic [`MKEY_DATA_BITS-1:0] resp_rdata;
  logic                       resp_ready;
  logic                       fw_app_mode;
  logic                       led_r;
  logic                       led_g;
  logic                       led_b;
  logic                       gpio1;
  logic                       gpio2;
  logic                       gpio3;
  logic                       gpio4;
  logic [15:0]                lfsr_state;
  int                         check_count = 0;

  mkey_top mkey_top_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .req_valid   (req_valid),
    .req_cmd     (req_cmd),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .resp_rdata  (resp_rdata),
    .resp_ready  (resp_ready),
    .fw_app_mode (fw_app_mode),
    .led_r       (led_r),
    .led_g       (led_g),
    .led_b       (led_b),
    .gpio1       (gpio1),
    .gpio2       (gpio2),
    .gpio3       (gpio3),
    .gpio4       (gpio4)
  );

  bind host_bridge mkey_checker mkey_checker_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .cs         (cs)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic string addr_name(input logic [`MKEY_ADDR_BITS-1:0] a);
    case (a)
      `MKEY_ADDR_NAME0:      return "NAME0";
      `MKEY_ADDR_NAME1:      return "NAME1";
      `MKEY_ADDR_VERSION:    return "VERSION";
      `MKEY_ADDR_SWITCH_APP: return "SWITCH_APP";
      `MKEY_ADDR_LED:        return "LED";
      `MKEY_ADDR_GPIO:       return "GPIO";
      `MKEY_ADDR_APP_START:  return "APP_START";
      `MKEY_ADDR_APP_SIZE:   return "APP_SIZE";
      `MKEY_ADDR_DEBUG:      return "DEBUG";
      default:               return $sformatf("addr 0x%02h", a);
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_word(input string name, input mkey_pkg::host_cmd_e cmd,
                            input logic [`MKEY_ADDR_BITS-1:0] addr,
                            input logic [`MKEY_DATA_BITS-1:0] expected,
                            input logic [`MKEY_DATA_BITS-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s %s %s expected 0x%08h actual 0x%08h",
                         name, cmd.name(), addr_name(addr), expected, actual));
    end
  endtask

  // Pin order is fw_app_mode, led_r, led_g, led_b, gpio4, gpio3
  task automatic check_pins(input string name, input logic [5:0] expected,
                            input logic [5:0] actual);
    check_count++;
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED %s pins expected 0x%02h actual 0x%02h",
                         name, expected, actual));
    end
  endtask

  //------------------------------
  // One host request and response
  //------------------------------
  task automatic host_access(input mkey_pkg::host_cmd_e cmd,
                             input logic [`MKEY_ADDR_BITS-1:0] addr,
                             input logic [`MKEY_DATA_BITS-1:0] wdata,
                             output logic [`MKEY_DATA_BITS-1:0] rdata);
    int         cycles;
    logic [2:0] idle;
    @(posedge clk);
    req_valid <= 1'b1;
    req_cmd   <= cmd;
    req_addr  <= addr;
    req_wdata <= wdata;
    cycles = 0;
    @(negedge clk);
    while (!req_ready) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_run($sformatf("Timeout, req_ready stayed low on %s", addr_name(addr)));
      end
      @(negedge clk);
    end
    // Request handshake edge
    @(posedge clk);
    req_valid <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (!resp_valid) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        fail_run($sformatf("Timeout, no response arrived for %s", addr_name(addr)));
      end
      @(negedge clk);
    end
    // Random back-pressure of 0 to 7 cycles
    idle = '0;
    repeat (3) begin
      idle = {idle[1:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    repeat (idle) @(negedge clk);
    rdata = resp_rdata;
    @(posedge clk);
    resp_ready <= 1'b1;
    @(posedge clk);
    resp_ready <= 1'b0;
  endtask

  //------------------------------
  // Trace player
  //------------------------------
  initial begin
    int                         fd;
    int                         fields;
    string                      line;
    string                      op;
    string                      name;
    logic [31:0]                col_a;
    logic [31:0]                col_d;
    logic [31:0]                col_e;
    logic [`MKEY_DATA_BITS-1:0] rdata;
    reset_n    = 1'b0;
    req_valid  = 1'b0;
    req_cmd    = mkey_pkg::CMD_READ;
    req_addr   = '0;
    req_wdata  = '0;
    resp_ready = 1'b0;
    gpio1      = 1'b0;
    gpio2      = 1'b0;
    lfsr_state = 16'd39572;
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;

    fd = $fopen("testbench/mkey_trace.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the trace file testbench/mkey_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      fields = $sscanf(line, "%s %s %h %h %h", op, name, col_a, col_d, col_e);
      if (fields != 5) begin
        fail_run($sformatf("Trace line is malformed: %s", line));
      end
      if (op == "W") begin
        host_access(mkey_pkg::CMD_WRITE, col_a[7:0], col_d, rdata);
        check_word(name, mkey_pkg::CMD_WRITE, col_a[7:0], col_e, rdata);
      end else if (op == "R") begin
        host_access(mkey_pkg::CMD_READ, col_a[7:0], '0, rdata);
        check_word(name, mkey_pkg::CMD_READ, col_a[7:0], col_e, rdata);
      end else if (op == "G") begin
        @(posedge clk);
        gpio1 <= col_a[0];
        gpio2 <= col_a[1];
        repeat (GPIO_SETTLE) @(posedge clk);
      end else if (op == "P") begin
        @(negedge clk);
        check_pins(name, col_e[5:0], {fw_app_mode, led_r, led_g, led_b, gpio4, gpio3});
      end else begin
        fail_run($sformatf("Unknown trace operation %s", op));
      end
    end
    $fclose(fd);

    if (check_count == 0) begin
      fail_run("The trace ran no checks");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

//--- testbench/mkey_trace.txt
# op name addr_or_pins data expected, all hex; W write, R read, G drive {gpio2,gpio1}
# P compares pins {fw_app_mode,led_r,led_g,led_b,gpio4,gpio3} with expected
P reset_pins 00 0 18
R name0 00 0 6d6b6579
R name1 01 0 6374726c
R version 02 0 00000001
R udi0 30 0 0a1b2c3d
R udi1 31 0 4e5f6071
R unmapped_03 03 0 0
R unmapped_28 28 0 0
R switch_before 08 0 0
W led_blue 09 fffffff1 0
P led_blue_pins 00 0 04
R led_masked 09 0 1
W gpio_out 0a 0000000c 0
P gpio_out_pins 00 0 07
G gpio_in 02 0 0
R gpio_read 0a 0 e
W app_start 0c 00008000 0
W app_size 0d 00001f00 0
W debug 10 deadbeef 0
W cdi0 20 a5a50000 0
W cdi1 21 a5a50011 0
W cdi2 22 a5a50022 0
W cdi3 23 a5a50033 0
W cdi4 24 a5a50044 0
W cdi5 25 a5a50055 0
W cdi6 26 a5a50066 0
W cdi7 27 a5a50077 0
R app_start_rd 0c 0 00008000
R app_size_rd 0d 0 00001f00
R debug_rd 10 0 deadbeef
R cdi0_rd 20 0 a5a50000
R cdi1_rd 21 0 a5a50011
R cdi2_rd 22 0 a5a50022
R cdi3_rd 23 0 a5a50033
R cdi4_rd 24 0 a5a50044
R cdi5_rd 25 0 a5a50055
R cdi6_rd 26 0 a5a50066
R cdi7_rd 27 0 a5a50077
W switch_app 08 12345678 0
P app_mode_pins 00 0 27
R switch_after 08 0 ffffffff
W app_start_locked 0c 11111111 0
W app_size_locked 0d 22222222 0
W cdi3_locked 23 33333333 0
R app_start_kept 0c 0 00008000
R app_size_kept 0d 0 00001f00
R cdi3_kept 23 0 a5a50033
W debug_after 10 0badf00d 0
R debug_after_rd 10 0 0badf00d
W led_green 09 2 0
R led_green_rd 09 0 2

//--- list.f
+incdir+logic
logic/mkey_pkg.sv
logic/host_bridge.sv
logic/sys_ctrl_regs.sv
logic/mkey_top.sv
testbench/mkey_checker.sv
testbench/mkey_tb.sv

//--- Makefile
# Verilator flow for the security key control block

VERILATOR  ?= verilator
TOP        ?= mkey_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
